//--- list.f
hw/core_pkg.sv
hw/fetch_if.sv
hw/alu.sv
hw/reg_file.sv
hw/instr_decoder.sv
hw/load_store_unit.sv
hw/execute_stage.sv
hw/fetch_stage.sv
hw/rv_core_top.sv
verification/rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module rv_core_tb -f list.f -Mdir obj_dir -o rv_core_sim \
    > build.log 2>&1 \
    && ./obj_dir/rv_core_sim > sim.log 2>&1 \
    || echo "TESTBENCH FAILED (build or run error, see build.log)" >> sim.log

cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

//--- verification/rv_core_tb.sv
// Testbench for rv_core_top that runs a small RV32I program from a table and checks each data store
`timescale 1ns/1ps

module rv_core_tb;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam logic [31:0] SEED     = 32'h1991_e848;
    localparam int          TIMEOUT  = 2000;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic        clk;
    logic        rst_n      = 1'b0;
    logic        imem_ready = 1'b0;
    logic        dmem_ready = 1'b0;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_rdata;
    logic        o_imem_valid;
    logic [31:0] o_imem_addr;
    logic        o_dmem_valid;
    logic        o_dmem_we;
    logic [31:0] o_dmem_addr;
    logic [31:0] o_dmem_wdata;
    logic [3:0]  o_dmem_be;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] lfsr = SEED;

    logic [31:0] prog_q [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_be [$];

    // Monitor copies of the ports from the previous edge
    int          cycle       = 0;
    logic        rst_q       = 1'b1;
    logic        imem_seen   = 1'b0;
    logic        dmem_seen   = 1'b0;
    logic        imem_pend   = 1'b0;
    logic        dmem_pend   = 1'b0;
    logic [31:0] imem_addr_q;
    logic        dmem_we_q;
    logic [31:0] dmem_addr_q;
    logic [31:0] dmem_wdata_q;
    logic [3:0]  dmem_be_q;

    rv_core_top #(
        .RESET_PC(RESET_PC)
    ) u_dut (
        .clk(clk),
        .rst_n(rst_n),
        .i_imem_ready(imem_ready),
        .i_imem_rdata(imem_rdata),
        .o_imem_valid(o_imem_valid),
        .o_imem_addr(o_imem_addr),
        .i_dmem_ready(dmem_ready),
        .i_dmem_rdata(dmem_rdata),
        .o_dmem_valid(o_dmem_valid),
        .o_dmem_we(o_dmem_we),
        .o_dmem_addr(o_dmem_addr),
        .o_dmem_wdata(o_dmem_wdata),
        .o_dmem_be(o_dmem_be)
    );

    // One ISA encoder per instruction format
    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_REG};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    function automatic logic store_handshake();
        return o_dmem_valid && o_dmem_we && dmem_ready;
    endfunction

    task automatic emit(input logic [31:0] instr);
        prog_q.push_back(instr);
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] be);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_be.push_back(be);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_store_handshake(input int idx);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!store_handshake() && cycles < TIMEOUT) begin
            cycles++;
            @(posedge clk);
        end
        if (!store_handshake()) begin
            $display("timeout: store %0d did not reach the data port in %0d cycles",
                     idx, TIMEOUT);
            $display("TESTBENCH FAILED");
            $fatal(1, "store wait timed out");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Memory models answer in the same cycle as ready
    assign imem_rdata = imem[o_imem_addr[9:2]];
    assign dmem_rdata = dmem[o_dmem_addr[9:2]];

    always @(posedge clk) begin
        if (store_handshake()) begin
            for (int b = 0; b < 4; b++) begin
                if (o_dmem_be[b]) begin
                    dmem[o_dmem_addr[9:2]][8*b +: 8] = o_dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin : ready_gen
        logic [31:0] s_imem;
        logic [31:0] s_dmem;
        if (!rst_n) begin
            imem_ready <= 1'b0;
            dmem_ready <= 1'b0;
        end else begin
            s_imem = lfsr_next(lfsr);
            s_dmem = lfsr_next(s_imem);
            lfsr       <= s_dmem;
            imem_ready <= s_imem[0];
            dmem_ready <= s_dmem[0];
        end
    end

    // Reset quiet, first requests, and stalled requests holding steady
    always @(posedge clk) begin
        if (cycle > 0) begin
            if (!rst_n || !rst_q) begin
                check_value("o_imem_valid", 32'(o_imem_valid), 32'd0);
                check_value("o_dmem_valid", 32'(o_dmem_valid), 32'd0);
            end
            if (o_imem_valid && !imem_seen) begin
                check_value("o_imem_addr", o_imem_addr, RESET_PC);
            end
            if (o_dmem_valid && !dmem_seen) begin
                check_value("o_dmem_we", 32'(o_dmem_we), 32'd1);
                check_value("o_dmem_addr", o_dmem_addr, exp_addr[0]);
            end
            if (imem_pend) begin
                check_value("o_imem_valid", 32'(o_imem_valid), 32'd1);
                check_value("o_imem_addr", o_imem_addr, imem_addr_q);
            end
            if (dmem_pend) begin
                check_value("o_dmem_valid", 32'(o_dmem_valid), 32'd1);
                check_value("o_dmem_we", 32'(o_dmem_we), 32'(dmem_we_q));
                check_value("o_dmem_addr", o_dmem_addr, dmem_addr_q);
                check_value("o_dmem_wdata", o_dmem_wdata, dmem_wdata_q);
                check_value("o_dmem_be", 32'(o_dmem_be), 32'(dmem_be_q));
            end
            imem_seen    <= imem_seen | o_imem_valid;
            dmem_seen    <= dmem_seen | o_dmem_valid;
            imem_pend    <= o_imem_valid & ~imem_ready;
            dmem_pend    <= o_dmem_valid & ~dmem_ready;
            imem_addr_q  <= o_imem_addr;
            dmem_we_q    <= o_dmem_we;
            dmem_addr_q  <= o_dmem_addr;
            dmem_wdata_q <= o_dmem_wdata;
            dmem_be_q    <= o_dmem_be;
        end
        rst_q <= rst_n;
        cycle <= cycle + 1;
    end

    initial begin
        logic [31:0] mask;

        // ALU results
        emit(enc_i(100, 0, 0, 1, OPC_IMM));
        emit(enc_i(-7, 0, 0, 2, OPC_IMM));
        emit(enc_r('h20, 1, 2, 0, 4));
        emit(enc_i(3, 0, 0, 5, OPC_IMM));
        emit(enc_r('h20, 5, 4, 5, 6));
        emit(enc_r(0, 1, 2, 2, 7));
        emit(enc_r(0, 1, 2, 3, 8));
        emit(enc_i('h401, 2, 5, 10, OPC_IMM));
        emit(enc_s('h200, 4, 0, 2));
        emit(enc_s('h204, 6, 0, 2));
        emit(enc_s('h208, 7, 0, 2));
        emit(enc_s('h20C, 8, 0, 2));
        emit(enc_s('h210, 10, 0, 2));
        // Loads of the word at 0x100 that are stored back afterwards
        emit(enc_i('h100, 0, 0, 11, OPC_LOAD));
        emit(enc_i('h103, 0, 4, 12, OPC_LOAD));
        emit(enc_i('h102, 0, 1, 13, OPC_LOAD));
        emit(enc_i('h102, 0, 5, 15, OPC_LOAD));
        emit(enc_i('h100, 0, 2, 16, OPC_LOAD));
        emit(enc_s('h214, 11, 0, 2));
        emit(enc_s('h218, 12, 0, 2));
        emit(enc_s('h21C, 13, 0, 2));
        emit(enc_s('h220, 15, 0, 2));
        emit(enc_s('h224, 16, 0, 2));
        emit(enc_s('h229, 16, 0, 0));
        emit(enc_s('h22E, 16, 0, 1));
        // Branches and jumps skip every store to 0x23C
        emit(enc_b(8, 8, 7, 0));
        emit(enc_s('h230, 1, 0, 2));
        emit(enc_b(8, 8, 7, 1));
        emit(enc_s('h23C, 2, 0, 2));
        emit(enc_b(8, 1, 2, 4));
        emit(enc_s('h23C, 2, 0, 2));
        emit(enc_j(8, 18));
        emit(enc_s('h23C, 2, 0, 2));
        emit(enc_s('h234, 18, 0, 2));
        emit(enc_i('h95, 0, 0, 19, OPC_IMM));
        emit(enc_i(0, 19, 0, 20, OPC_JALR));
        emit(enc_s('h23C, 2, 0, 2));
        emit(enc_s('h238, 20, 0, 2));
        emit(enc_u(1, 22, OPC_AUIPC));
        emit(enc_s('h240, 22, 0, 2));
        // Completion store followed by a jump to itself
        emit(enc_i(1, 0, 0, 21, OPC_IMM));
        emit(enc_s('h3FC, 21, 0, 2));
        emit(enc_j(0, 0));

        expect_store(32'h0000_0200, 32'hFFFF_FF95, 4'b1111);
        expect_store(32'h0000_0204, 32'hFFFF_FFF2, 4'b1111);
        expect_store(32'h0000_0208, 32'h0000_0001, 4'b1111);
        expect_store(32'h0000_020C, 32'h0000_0000, 4'b1111);
        expect_store(32'h0000_0210, 32'hFFFF_FFFC, 4'b1111);
        expect_store(32'h0000_0214, 32'hFFFF_FF81, 4'b1111);
        expect_store(32'h0000_0218, 32'h0000_00C6, 4'b1111);
        expect_store(32'h0000_021C, 32'hFFFF_C634, 4'b1111);
        expect_store(32'h0000_0220, 32'h0000_C634, 4'b1111);
        expect_store(32'h0000_0224, 32'hC634_7F81, 4'b1111);
        expect_store(32'h0000_0228, 32'h0000_8100, 4'b0010);
        expect_store(32'h0000_022C, 32'h7F81_0000, 4'b1100);
        expect_store(32'h0000_0230, 32'h0000_0064, 4'b1111);
        expect_store(32'h0000_0234, 32'h0000_0080, 4'b1111);
        expect_store(32'h0000_0238, 32'h0000_0090, 4'b1111);
        expect_store(32'h0000_0240, 32'h0000_1098, 4'b1111);
        expect_store(32'h0000_03FC, 32'h0000_0001, 4'b1111);

        // Unused words hold addi x0, x0, index
        for (int k = 0; k < 256; k++) begin
            imem[k] = enc_i(k, 0, 0, 0, OPC_IMM);
            dmem[k] = {k[7:0] ^ 8'h3c, ~k[7:0], k[7:0] + 8'd17, k[7:0]};
        end
        for (int k = 0; k < prog_q.size(); k++) begin
            imem[k] = prog_q[k];
        end
        // Bytes 0x81, 0x7F, 0x34, 0xC6 from low address up
        dmem[64] = 32'hC634_7F81;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < exp_addr.size(); i++) begin
            wait_store_handshake(i);
            mask = lane_mask(exp_be[i]);
            check_value("o_dmem_addr", o_dmem_addr, exp_addr[i]);
            check_value("o_dmem_be", 32'(o_dmem_be), 32'(exp_be[i]));
            check_value("o_dmem_wdata", o_dmem_wdata & mask, exp_data[i] & mask);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- hw/rv_core_top.sv
// RV32I core top with a fetch and an execute stage behind two plain memory ports
`timescale 1ns/1ps

module rv_core_top #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_imem_ready,
    input  logic [core_pkg::XLEN-1:0] i_imem_rdata,
    output logic                      o_imem_valid,
    output logic [core_pkg::XLEN-1:0] o_imem_addr,
    input  logic                      i_dmem_ready,
    input  logic [core_pkg::XLEN-1:0] i_dmem_rdata,
    output logic                      o_dmem_valid,
    output logic                      o_dmem_we,
    output logic [core_pkg::XLEN-1:0] o_dmem_addr,
    output logic [core_pkg::XLEN-1:0] o_dmem_wdata,
    output logic [3:0]                o_dmem_be
);

    fetch_if u_fif ();

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk(clk),
        .rst_n(rst_n),
        .i_imem_ready(i_imem_ready),
        .i_imem_rdata(i_imem_rdata),
        .o_imem_valid(o_imem_valid),
        .o_imem_addr(o_imem_addr),
        .f(u_fif.fetch)
    );

    execute_stage u_exec (
        .clk(clk),
        .rst_n(rst_n),
        .f(u_fif.execute),
        .i_dmem_ready(i_dmem_ready),
        .i_dmem_rdata(i_dmem_rdata),
        .o_dmem_valid(o_dmem_valid),
        .o_dmem_we(o_dmem_we),
        .o_dmem_addr(o_dmem_addr),
        .o_dmem_wdata(o_dmem_wdata),
        .o_dmem_be(o_dmem_be)
    );

endmodule

//--- hw/fetch_stage.sv
// Fetch stage that requests instruction words and holds one for execute in a buffer
`timescale 1ns/1ps

module fetch_stage #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_imem_ready,
    input  logic [core_pkg::XLEN-1:0] i_imem_rdata,
    output logic                      o_imem_valid,
    output logic [core_pkg::XLEN-1:0] o_imem_addr,
    fetch_if.fetch                    f
);

    logic [core_pkg::XLEN-1:0] pc;
    logic [core_pkg::XLEN-1:0] redir_pc;
    logic                      req_active;
    logic                      discard;
    logic                      buf_valid;
    core_pkg::instr_t          buf_instr;
    logic [core_pkg::XLEN-1:0] buf_pc;
    logic                      hs;
    logic                      keep;
    logic                      buf_free;

    assign hs = req_active & i_imem_ready;
    // Returned word goes to the buffer unless a redirect has overtaken it
    assign keep = hs & ~discard & ~f.redirect;
    // Buffer is empty next cycle, so a new request may start
    assign buf_free = ~keep & (~buf_valid | f.ready | f.redirect);

    assign o_imem_valid = req_active;
    assign o_imem_addr  = pc;
    assign f.valid      = buf_valid;
    assign f.instr      = buf_instr;
    assign f.pc         = buf_pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_active <= 1'b0;
            discard    <= 1'b0;
            buf_valid  <= 1'b0;
            pc         <= RESET_PC;
        end else begin
            req_active <= (req_active & ~hs) | buf_free;
            buf_valid  <= keep | (buf_valid & ~f.ready & ~f.redirect);
            if (f.redirect && req_active && !hs) begin
                // Address must hold, so park the target until the old word returns
                discard  <= 1'b1;
                redir_pc <= f.redirect_pc;
            end else if (f.redirect) begin
                discard <= 1'b0;
                pc      <= f.redirect_pc;
            end else if (hs) begin
                discard <= 1'b0;
                pc      <= discard ? redir_pc : pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hs) begin
            buf_instr.raw <= i_imem_rdata;
            buf_pc        <= pc;
        end
    end

endmodule

//--- hw/execute_stage.sv
// Execute stage that decodes, runs the ALU or a memory access, writes back and redirects
`timescale 1ns/1ps

module execute_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    fetch_if.execute                  f,
    input  logic                      i_dmem_ready,
    input  logic [core_pkg::XLEN-1:0] i_dmem_rdata,
    output logic                      o_dmem_valid,
    output logic                      o_dmem_we,
    output logic [core_pkg::XLEN-1:0] o_dmem_addr,
    output logic [core_pkg::XLEN-1:0] o_dmem_wdata,
    output logic [3:0]                o_dmem_be
);

    logic [core_pkg::REG_ADDR_W-1:0] rs1;
    logic [core_pkg::REG_ADDR_W-1:0] rs2;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    logic [core_pkg::XLEN-1:0]       imm;
    logic [core_pkg::ALU_OP_W-1:0]   alu_op;
    logic                            alu_use_imm;
    logic                            reg_write;
    logic [core_pkg::WB_SEL_W-1:0]   wb_sel;
    logic                            is_load;
    logic                            is_store;
    logic                            is_branch;
    logic                            is_jump;
    logic                            adder_from_reg;
    logic [2:0]                      funct3;
    logic [core_pkg::XLEN-1:0]       rdata1;
    logic [core_pkg::XLEN-1:0]       rdata2;
    logic [core_pkg::XLEN-1:0]       alu_b;
    logic [core_pkg::XLEN-1:0]       alu_result;
    logic                            branch_taken;
    logic [core_pkg::XLEN-1:0]       adder_sum;
    logic [core_pkg::XLEN-1:0]       adder_result;
    logic [core_pkg::XLEN-1:0]       load_data;
    logic                            mem_done;
    logic                            is_mem;
    logic                            commit;
    logic [core_pkg::XLEN-1:0]       wb_data;

    instr_decoder u_dec (
        .i_instr(f.instr), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
        .o_alu_op(alu_op), .o_alu_use_imm(alu_use_imm), .o_reg_write(reg_write),
        .o_wb_sel(wb_sel), .o_is_load(is_load), .o_is_store(is_store),
        .o_is_branch(is_branch), .o_is_jump(is_jump),
        .o_adder_from_reg(adder_from_reg), .o_funct3(funct3)
    );

    reg_file u_rf (
        .clk(clk), .i_rs1(rs1), .i_rs2(rs2), .o_rdata1(rdata1), .o_rdata2(rdata2),
        .i_we(commit & reg_write & rst_n), .i_rd(rd), .i_wdata(wb_data)
    );

    assign alu_b = alu_use_imm ? imm : rdata2;

    alu u_alu (
        .i_op(alu_op), .i_a(rdata1), .i_b(alu_b), .i_funct3(funct3),
        .o_result(alu_result), .o_branch_taken(branch_taken)
    );

    // Second adder gives branch, JAL, JALR and AUIPC targets
    assign adder_sum    = (adder_from_reg ? rdata1 : f.pc) + imm;
    assign adder_result = adder_from_reg ? {adder_sum[core_pkg::XLEN-1:1], 1'b0} : adder_sum;

    assign is_mem = is_load | is_store;

    load_store_unit u_lsu (
        .i_start(f.valid & is_mem), .i_is_store(is_store), .i_addr(alu_result),
        .i_store_data(rdata2), .i_funct3(funct3), .i_dmem_ready(i_dmem_ready),
        .i_dmem_rdata(i_dmem_rdata), .o_dmem_valid(o_dmem_valid), .o_dmem_we(o_dmem_we),
        .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata), .o_dmem_be(o_dmem_be),
        .o_load_data(load_data), .o_done(mem_done)
    );

    // Memory instructions wait here until the data port answers
    assign f.ready = ~is_mem | mem_done;
    assign commit  = f.valid & f.ready;

    always_comb begin
        case (wb_sel)
            core_pkg::WB_LOAD:  wb_data = load_data;
            core_pkg::WB_PC4:   wb_data = f.pc + 32'd4;
            core_pkg::WB_ADDER: wb_data = adder_result;
            default:            wb_data = alu_result;
        endcase
    end

    assign f.redirect    = commit & (is_jump | (is_branch & branch_taken));
    assign f.redirect_pc = adder_result;

endmodule

//--- hw/load_store_unit.sv
// Data port request, store lane alignment with byte enables, and load extension
`timescale 1ns/1ps

module load_store_unit (
    input  logic                      i_start,
    input  logic                      i_is_store,
    input  logic [core_pkg::XLEN-1:0] i_addr,
    input  logic [core_pkg::XLEN-1:0] i_store_data,
    input  logic [2:0]                i_funct3,
    input  logic                      i_dmem_ready,
    input  logic [core_pkg::XLEN-1:0] i_dmem_rdata,
    output logic                      o_dmem_valid,
    output logic                      o_dmem_we,
    output logic [core_pkg::XLEN-1:0] o_dmem_addr,
    output logic [core_pkg::XLEN-1:0] o_dmem_wdata,
    output logic [3:0]                o_dmem_be,
    output logic [core_pkg::XLEN-1:0] o_load_data,
    output logic                      o_done
);

    logic [core_pkg::XLEN-1:0] shifted;

    assign o_dmem_valid = i_start;
    assign o_dmem_we    = i_is_store;
    assign o_dmem_addr  = {i_addr[core_pkg::XLEN-1:2], 2'b00};
    assign o_done       = i_start & i_dmem_ready;

    // Replicating the low bytes puts them on every lane, enables pick the right one
    always_comb begin
        case (i_funct3)
            core_pkg::F3_B, core_pkg::F3_BU: begin
                o_dmem_wdata = {4{i_store_data[7:0]}};
                o_dmem_be    = 4'b0001 << i_addr[1:0];
            end
            core_pkg::F3_H, core_pkg::F3_HU: begin
                o_dmem_wdata = {2{i_store_data[15:0]}};
                o_dmem_be    = 4'b0011 << {i_addr[1], 1'b0};
            end
            core_pkg::F3_W: begin
                o_dmem_wdata = i_store_data;
                o_dmem_be    = 4'b1111;
            end
            default: begin
                o_dmem_wdata = i_store_data;
                o_dmem_be    = 4'b0000;
            end
        endcase
    end

    // Bring the addressed lane down to bit 0 before extending
    assign shifted = i_dmem_rdata >> {i_addr[1:0], 3'b000};

    always_comb begin
        case (i_funct3)
            core_pkg::F3_B:  o_load_data = {{24{shifted[7]}}, shifted[7:0]};
            core_pkg::F3_BU: o_load_data = {24'b0, shifted[7:0]};
            core_pkg::F3_H:  o_load_data = {{16{shifted[15]}}, shifted[15:0]};
            core_pkg::F3_HU: o_load_data = {16'b0, shifted[15:0]};
            default:         o_load_data = i_dmem_rdata;
        endcase
    end

endmodule

//--- hw/instr_decoder.sv
// Decodes one RV32I word into register addresses, immediate and execute controls
`timescale 1ns/1ps

module instr_decoder (
    input  core_pkg::instr_t                   i_instr,
    output logic [core_pkg::REG_ADDR_W-1:0]    o_rs1,
    output logic [core_pkg::REG_ADDR_W-1:0]    o_rs2,
    output logic [core_pkg::REG_ADDR_W-1:0]    o_rd,
    output logic [core_pkg::XLEN-1:0]          o_imm,
    output logic [core_pkg::ALU_OP_W-1:0]      o_alu_op,
    output logic                               o_alu_use_imm,
    output logic                               o_reg_write,
    output logic [core_pkg::WB_SEL_W-1:0]      o_wb_sel,
    output logic                               o_is_load,
    output logic                               o_is_store,
    output logic                               o_is_branch,
    output logic                               o_is_jump,
    output logic                               o_adder_from_reg,
    output logic [2:0]                         o_funct3
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt_op;

    assign opcode   = i_instr.r.opcode;
    assign funct3   = i_instr.r.funct3;
    assign o_funct3 = funct3;
    assign o_rs2    = i_instr.r.rs2;
    assign o_rd     = i_instr.r.rd;
    // LUI reads x0 so the ALU just passes its immediate
    assign o_rs1 = (opcode == core_pkg::OP_LUI) ? '0 : i_instr.r.rs1;
    // Bit 30 picks SRA for both forms, SUB only for register form
    assign alt_op = i_instr.r.funct7[5] &&
                    (funct3 == 3'b101 || (opcode == core_pkg::OP_REG && funct3 == 3'b000));

    always_comb begin
        o_imm            = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
        o_alu_op         = core_pkg::ALU_ADD;
        o_alu_use_imm    = 1'b0;
        o_reg_write      = 1'b0;
        o_wb_sel         = core_pkg::WB_ALU;
        o_is_load        = 1'b0;
        o_is_store       = 1'b0;
        o_is_branch      = 1'b0;
        o_is_jump        = 1'b0;
        o_adder_from_reg = 1'b0;
        case (opcode)
            core_pkg::OP_LUI: begin
                o_imm         = {i_instr.u.imm, 12'b0};
                o_alu_use_imm = 1'b1;
                o_reg_write   = 1'b1;
            end
            core_pkg::OP_AUIPC: begin
                o_imm       = {i_instr.u.imm, 12'b0};
                o_reg_write = 1'b1;
                o_wb_sel    = core_pkg::WB_ADDER;
            end
            core_pkg::OP_JAL: begin
                o_imm       = {{11{i_instr.j.imm20}}, i_instr.j.imm20, i_instr.j.imm19_12,
                               i_instr.j.imm11, i_instr.j.imm10_1, 1'b0};
                o_reg_write = 1'b1;
                o_wb_sel    = core_pkg::WB_PC4;
                o_is_jump   = 1'b1;
            end
            core_pkg::OP_JALR: begin
                o_reg_write      = 1'b1;
                o_wb_sel         = core_pkg::WB_PC4;
                o_is_jump        = 1'b1;
                o_adder_from_reg = 1'b1;
            end
            core_pkg::OP_BRANCH: begin
                o_imm       = {{19{i_instr.b.imm12}}, i_instr.b.imm12, i_instr.b.imm11,
                               i_instr.b.imm10_5, i_instr.b.imm4_1, 1'b0};
                o_is_branch = 1'b1;
            end
            core_pkg::OP_LOAD: begin
                o_alu_use_imm = 1'b1;
                o_reg_write   = 1'b1;
                o_wb_sel      = core_pkg::WB_LOAD;
                o_is_load     = 1'b1;
            end
            core_pkg::OP_STORE: begin
                o_imm         = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
                o_alu_use_imm = 1'b1;
                o_is_store    = 1'b1;
            end
            core_pkg::OP_IMM: begin
                o_alu_op      = {alt_op, funct3};
                o_alu_use_imm = 1'b1;
                o_reg_write   = 1'b1;
            end
            core_pkg::OP_REG: begin
                o_alu_op    = {alt_op, funct3};
                o_reg_write = 1'b1;
            end
            // FENCE, SYSTEM and unknown words retire with no effect
            default: ;
        endcase
    end

endmodule

//--- hw/reg_file.sv
// Register file with two asynchronous read ports and one clocked write port
`timescale 1ns/1ps

module reg_file (
    input  logic                            clk,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_rs2,
    output logic [core_pkg::XLEN-1:0]       o_rdata1,
    output logic [core_pkg::XLEN-1:0]       o_rdata2,
    input  logic                            i_we,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic [core_pkg::XLEN-1:0]       i_wdata
);

    // x0 has no storage
    logic [core_pkg::XLEN-1:0] regs [1:31];

    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

    always_ff @(posedge clk) begin
        if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

endmodule

//--- hw/alu.sv
// Integer ALU for RV32I operations plus the branch condition on the same operands
`timescale 1ns/1ps

module alu (
    input  logic [core_pkg::ALU_OP_W-1:0] i_op,
    input  logic [core_pkg::XLEN-1:0]     i_a,
    input  logic [core_pkg::XLEN-1:0]     i_b,
    input  logic [2:0]                    i_funct3,
    output logic [core_pkg::XLEN-1:0]     o_result,
    output logic                          o_branch_taken
);

    logic       lt_s;
    logic       lt_u;
    logic       eq;
    logic [4:0] shamt;

    assign lt_s  = $signed(i_a) < $signed(i_b);
    assign lt_u  = i_a < i_b;
    assign eq    = i_a == i_b;
    assign shamt = i_b[4:0];

    always_comb begin
        case (i_op)
            core_pkg::ALU_ADD:  o_result = i_a + i_b;
            core_pkg::ALU_SUB:  o_result = i_a - i_b;
            core_pkg::ALU_SLL:  o_result = i_a << shamt;
            core_pkg::ALU_SLT:  o_result = {{(core_pkg::XLEN-1){1'b0}}, lt_s};
            core_pkg::ALU_SLTU: o_result = {{(core_pkg::XLEN-1){1'b0}}, lt_u};
            core_pkg::ALU_XOR:  o_result = i_a ^ i_b;
            core_pkg::ALU_SRL:  o_result = i_a >> shamt;
            core_pkg::ALU_SRA:  o_result = $signed(i_a) >>> shamt;
            core_pkg::ALU_OR:   o_result = i_a | i_b;
            core_pkg::ALU_AND:  o_result = i_a & i_b;
            default:            o_result = '0;
        endcase
    end

    // BEQ, BNE, BLT, BGE, BLTU, BGEU by funct3
    always_comb begin
        case (i_funct3)
            3'b000:  o_branch_taken = eq;
            3'b001:  o_branch_taken = ~eq;
            3'b100:  o_branch_taken = lt_s;
            3'b101:  o_branch_taken = ~lt_s;
            3'b110:  o_branch_taken = lt_u;
            3'b111:  o_branch_taken = ~lt_u;
            default: o_branch_taken = 1'b0;
        endcase
    end

endmodule

//--- hw/fetch_if.sv
// Fetch to execute link, one instruction per valid/ready transfer and a redirect back
`timescale 1ns/1ps

interface fetch_if;

    logic                      valid;
    core_pkg::instr_t          instr;
    logic [core_pkg::XLEN-1:0] pc;
    logic                      ready;
    // One-cycle pulse on a taken branch or jump
    logic                      redirect;
    logic [core_pkg::XLEN-1:0] redirect_pc;

    modport fetch (output valid, instr, pc, input ready, redirect, redirect_pc);
    modport execute (input valid, instr, pc, output ready, redirect, redirect_pc);

endinterface

//--- hw/core_pkg.sv
// Shared RV32I widths, encodings and the instruction word type used across the core
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 4;
    localparam int WB_SEL_W   = 2;

    // One fetched word, read through whichever format its opcode calls for
    typedef union packed {
        logic [XLEN-1:0] raw;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_t;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // Low bits follow funct3, bit 3 is the alternate form (SUB, SRA)
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'b0000;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'b1000;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'b0001;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'b0010;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'b0011;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'b0100;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'b0101;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'b1101;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'b0110;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'b0111;

    localparam logic [WB_SEL_W-1:0] WB_ALU   = 2'b00;
    localparam logic [WB_SEL_W-1:0] WB_LOAD  = 2'b01;
    localparam logic [WB_SEL_W-1:0] WB_PC4   = 2'b10;
    localparam logic [WB_SEL_W-1:0] WB_ADDER = 2'b11;

    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

endpackage
